//--- Makefile
# Verilator build and run of the AXI4-Lite register bank testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_axi_lite_regs
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Test completed successfully

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# build the simulation binary from the file list
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# run, keep the log, and fail unless the pass line is in it
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "pass line not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src/axi_lite_consts.svh
// bus widths and register map of the AXI4-Lite register bank, include wherever the map is needed
`ifndef AXI_LITE_CONSTS_SVH
`define AXI_LITE_CONSTS_SVH

// ----------------------------------------------------------------------
// bus widths
// ----------------------------------------------------------------------
`define AXI_ADDR_W     32              // awaddr / araddr
`define AXI_DATA_W     32              // wdata / rdata, full word only
`define AXI_RESP_W     2               // bresp / rresp

// ----------------------------------------------------------------------
// register map
// ----------------------------------------------------------------------
// four word registers sitting right above the base address
`define REG_COUNT      4               // number of rw registers
`define REG_IDX_W      2               // clog2 of REG_COUNT

`define REG_BASE_ADDR  32'h43C0_0000   // bus address of register 0
`define REG_BYTE_OFS   4               // byte stride between registers

// offsets in use
//   0x0  reg 0
//   0x4  reg 1
//   0x8  reg 2
//   0xC  reg 3
// anything else answers slverr

`endif

//--- src/axi_lite_pkg.sv
// shared types of the AXI4-Lite register bank, imported by the channel controllers and the top
`include "axi_lite_consts.svh"

package axi_lite_pkg;

  // ----------------------------------------------------------------------
  // response codes
  // ----------------------------------------------------------------------
  // exokay and decerr never produced by this slave
  typedef enum logic [`AXI_RESP_W-1:0] {
    resp_okay   = 2'b00,   // access done
    resp_slverr = 2'b10    // address outside the window or misaligned
  } axi_resp_e;

  // ----------------------------------------------------------------------
  // channel FSM states
  // ----------------------------------------------------------------------
  // write side, gather aw and w then answer on b
  typedef enum logic {
    wr_collect = 1'b0,     // gathering address and data
    wr_resp    = 1'b1      // bvalid up, waiting on bready
  } wr_state_e;

  // read side, one request in flight
  typedef enum logic {
    rd_idle = 1'b0,        // arready up
    rd_data = 1'b1         // rvalid up, waiting on rready
  } rd_state_e;

endpackage

//--- src/axi_lite_regs_top.sv
// top of the AXI4-Lite register bank, joins the write and read FSMs to the registers
`timescale 1ns/1ps
`include "axi_lite_consts.svh"

module axi_lite_regs_top
  import axi_lite_pkg::*;
(
  input  logic                   SAXI_aclk,
  input  logic                   rst,
  // write address
  input  logic [`AXI_ADDR_W-1:0] s_awaddr_i,
  input  logic                   s_awvalid_i,
  output logic                   s_awready_o,
  // write data
  input  logic [`AXI_DATA_W-1:0] s_wdata_i,
  input  logic                   s_wvalid_i,
  output logic                   s_wready_o,
  // write response
  output axi_resp_e              s_bresp_o,
  output logic                   s_bvalid_o,
  input  logic                   s_bready_i,
  // read address
  input  logic [`AXI_ADDR_W-1:0] s_araddr_i,
  input  logic                   s_arvalid_i,
  output logic                   s_arready_o,
  // read data
  output logic [`AXI_DATA_W-1:0] s_rdata_o,
  output axi_resp_e              s_rresp_o,
  output logic                   s_rvalid_o,
  input  logic                   s_rready_i
);

  // ----------------------------------------------------------------------
  // internal bank ports
  // ----------------------------------------------------------------------
  logic                   wr_en;
  logic [`AXI_ADDR_W-1:0] wr_addr;
  logic [`AXI_DATA_W-1:0] wr_data;
  logic                   wr_err;   // comb answer from the bank
  logic [`AXI_ADDR_W-1:0] rd_addr;
  logic [`AXI_DATA_W-1:0] rd_data;
  logic                   rd_err;

  axi_write_ctrl axi_write_ctrl_inst (
    .SAXI_aclk   (SAXI_aclk),
    .rst         (rst),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bresp_o   (s_bresp_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .wr_en_o     (wr_en),
    .wr_addr_o   (wr_addr),
    .wr_data_o   (wr_data),
    .wr_err_i    (wr_err)
  );

  axi_read_ctrl axi_read_ctrl_inst (
    .SAXI_aclk   (SAXI_aclk),
    .rst         (rst),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .rd_addr_o   (rd_addr),
    .rd_data_i   (rd_data),
    .rd_err_i    (rd_err)
  );

  // only place that decodes addresses
  reg_bank reg_bank_inst (
    .SAXI_aclk (SAXI_aclk),
    .rst       (rst),
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .wr_err_o  (wr_err),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data),
    .rd_err_o  (rd_err)
  );

endmodule

//--- src/axi_read_ctrl.sv
// AXI4-Lite read channels (ar, r), one request at a time with a registered data beat
`timescale 1ns/1ps
`include "axi_lite_consts.svh"

module axi_read_ctrl
  import axi_lite_pkg::*;
(
  input  logic                   SAXI_aclk,
  input  logic                   rst,
  // read address channel
  input  logic [`AXI_ADDR_W-1:0] s_araddr_i,
  input  logic                   s_arvalid_i,
  output logic                   s_arready_o,
  // read data channel
  output logic [`AXI_DATA_W-1:0] s_rdata_o,
  output axi_resp_e              s_rresp_o,
  output logic                   s_rvalid_o,
  input  logic                   s_rready_i,
  // towards the register bank
  output logic [`AXI_ADDR_W-1:0] rd_addr_o,
  input  logic [`AXI_DATA_W-1:0] rd_data_i,
  input  logic                   rd_err_i
);

  rd_state_e state_q;
  logic      ar_hs;
  logic      r_hs;

  // ----------------------------------------------------------------------
  // handshakes
  // ----------------------------------------------------------------------
  assign s_arready_o = (state_q == rd_idle);   // blocked while a beat is pending
  assign s_rvalid_o  = (state_q == rd_data);

  assign ar_hs = s_arvalid_i && s_arready_o;
  assign r_hs  = s_rvalid_o && s_rready_i;

  // bank lookup is combinational, address goes straight through
  assign rd_addr_o = s_araddr_i;

  // ----------------------------------------------------------------------
  // data beat
  // ----------------------------------------------------------------------
  // sampled on the ar edge, then frozen until rready
  always_ff @(posedge SAXI_aclk) begin
    if (ar_hs) begin
      s_rdata_o <= rd_data_i;   // already zero on a miss
    end
  end

  // ----------------------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge SAXI_aclk) begin
    if (rst) begin
      state_q   <= rd_idle;
      s_rresp_o <= resp_okay;
    end else begin
      case (state_q)
        rd_idle: begin
          if (ar_hs) begin
            s_rresp_o <= rd_err_i ? resp_slverr : resp_okay;
            state_q   <= rd_data;   // rvalid up on this edge
          end
        end
        rd_data: begin
          if (r_hs) begin
            state_q <= rd_idle;
          end
        end
        default: state_q <= rd_idle;
      endcase
    end
  end

endmodule

//--- src/axi_write_ctrl.sv
// AXI4-Lite write channels (aw, w, b), gathers address and data in any order and commits to the bank
`timescale 1ns/1ps
`include "axi_lite_consts.svh"

module axi_write_ctrl
  import axi_lite_pkg::*;
(
  input  logic                   SAXI_aclk,
  input  logic                   rst,
  // write address channel
  input  logic [`AXI_ADDR_W-1:0] s_awaddr_i,
  input  logic                   s_awvalid_i,
  output logic                   s_awready_o,
  // write data channel
  input  logic [`AXI_DATA_W-1:0] s_wdata_i,
  input  logic                   s_wvalid_i,
  output logic                   s_wready_o,
  // write response channel
  output axi_resp_e              s_bresp_o,
  output logic                   s_bvalid_o,
  input  logic                   s_bready_i,
  // towards the register bank
  output logic                   wr_en_o,
  output logic [`AXI_ADDR_W-1:0] wr_addr_o,
  output logic [`AXI_DATA_W-1:0] wr_data_o,
  input  logic                   wr_err_i
);

  wr_state_e              state_q;
  logic                   aw_held_q;   // address captured
  logic                   w_held_q;    // data captured
  logic [`AXI_ADDR_W-1:0] addr_q;
  logic [`AXI_DATA_W-1:0] data_q;
  logic                   wr_en_q;     // commit strobe, one cycle
  logic                   aw_hs;
  logic                   w_hs;
  logic                   b_hs;

  // ----------------------------------------------------------------------
  // handshakes
  // ----------------------------------------------------------------------
  // each ready drops as soon as its item is held, and both stay low in wr_resp
  assign s_awready_o = (state_q == wr_collect) && !aw_held_q;
  assign s_wready_o  = (state_q == wr_collect) && !w_held_q;
  assign s_bvalid_o  = (state_q == wr_resp);

  assign aw_hs = s_awvalid_i && s_awready_o;
  assign w_hs  = s_wvalid_i && s_wready_o;
  assign b_hs  = s_bvalid_o && s_bready_i;

  // ----------------------------------------------------------------------
  // payload capture
  // ----------------------------------------------------------------------
  always_ff @(posedge SAXI_aclk) begin
    if (aw_hs) begin
      addr_q <= s_awaddr_i;
    end
    if (w_hs) begin
      data_q <= s_wdata_i;
    end
  end

  // ----------------------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge SAXI_aclk) begin
    if (rst) begin
      state_q   <= wr_collect;
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
      wr_en_q   <= 1'b0;
      s_bresp_o <= resp_okay;
    end else begin
      wr_en_q <= 1'b0;   // default, strobe lasts one cycle
      case (state_q)
        wr_collect: begin
          if (aw_hs) begin
            aw_held_q <= 1'b1;
          end
          if (w_hs) begin
            w_held_q <= 1'b1;
          end
          // both held, fire the commit once
          if (aw_held_q && w_held_q && !wr_en_q) begin
            wr_en_q <= 1'b1;
          end
          // commit cycle, bank answers error in the same cycle
          if (wr_en_q) begin
            s_bresp_o <= wr_err_i ? resp_slverr : resp_okay;
            state_q   <= wr_resp;
          end
        end
        wr_resp: begin
          if (b_hs) begin   // master took it, free both slots
            aw_held_q <= 1'b0;
            w_held_q  <= 1'b0;
            state_q   <= wr_collect;
          end
        end
        default: state_q <= wr_collect;
      endcase
    end
  end

  assign wr_en_o   = wr_en_q;
  assign wr_addr_o = addr_q;
  assign wr_data_o = data_q;

endmodule

//--- src/reg_bank.sv
// four-word register file with address decode, instantiated by the top below both channel FSMs
`timescale 1ns/1ps
`include "axi_lite_consts.svh"

module reg_bank (
  input  logic                   SAXI_aclk,
  input  logic                   rst,
  // write port
  input  logic                   wr_en_i,    // one-cycle commit strobe
  input  logic [`AXI_ADDR_W-1:0] wr_addr_i,
  input  logic [`AXI_DATA_W-1:0] wr_data_i,
  output logic                   wr_err_o,   // address did not decode
  // read port, combinational
  input  logic [`AXI_ADDR_W-1:0] rd_addr_i,
  output logic [`AXI_DATA_W-1:0] rd_data_o,
  output logic                   rd_err_o
);

  // ----------------------------------------------------------------------
  // decode helpers
  // ----------------------------------------------------------------------
  // offset from base must be inside the window and on a word boundary
  function automatic logic addr_hit(input logic [`AXI_ADDR_W-1:0] addr);
    logic [`AXI_ADDR_W-1:0] ofs;
    ofs = addr - `REG_BASE_ADDR;   // wraps for addresses below base
    return (ofs < `REG_COUNT * `REG_BYTE_OFS) && (ofs % `REG_BYTE_OFS == 0);
  endfunction

  function automatic logic [`REG_IDX_W-1:0] addr_idx(input logic [`AXI_ADDR_W-1:0] addr);
    logic [`AXI_ADDR_W-1:0] ofs;
    ofs = addr - `REG_BASE_ADDR;
    return `REG_IDX_W'(ofs / `REG_BYTE_OFS);   // word index
  endfunction

  logic [`AXI_DATA_W-1:0] regs_q [`REG_COUNT];   // the registers
  logic                   wr_hit;
  logic                   rd_hit;
  logic [`REG_IDX_W-1:0]  wr_idx;
  logic [`REG_IDX_W-1:0]  rd_idx;

  assign wr_hit = addr_hit(wr_addr_i);
  assign wr_idx = addr_idx(wr_addr_i);
  assign rd_hit = addr_hit(rd_addr_i);
  assign rd_idx = addr_idx(rd_addr_i);

  // ----------------------------------------------------------------------
  // write commit
  // ----------------------------------------------------------------------
  // bad address, strobe is ignored and only the error goes back
  assign wr_err_o = ~wr_hit;

  always_ff @(posedge SAXI_aclk) begin
    if (rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && wr_hit) begin
      regs_q[wr_idx] <= wr_data_i;   // full word, no strobes
    end
  end

  // ----------------------------------------------------------------------
  // read mux
  // ----------------------------------------------------------------------
  always_comb begin
    rd_err_o  = ~rd_hit;
    rd_data_o = rd_hit ? regs_q[rd_idx] : '0;   // zero on a miss
  end

endmodule

//--- tb.f
+incdir+src
src/axi_lite_pkg.sv
src/reg_bank.sv
src/axi_write_ctrl.sv
src/axi_read_ctrl.sv
src/axi_lite_regs_top.sv
verification/tb_axi_lite_regs.sv

//--- verification/tb_axi_lite_regs.sv
// testbench for the AXI4-Lite register bank, drives all five channels against a register model
`timescale 1ns/1ps
`include "axi_lite_consts.svh"

module tb_axi_lite_regs
  import axi_lite_pkg::*;
();

  localparam int CLK_NS          = 4;
  localparam int RST_CYCLES      = 16;
  localparam int TXN_TOTAL       = 242;   // sum over all six tests
  localparam int WATCHDOG_CYCLES = TXN_TOTAL * 40 + RST_CYCLES;

  logic                   SAXI_aclk;
  logic                   rst;
  logic [`AXI_ADDR_W-1:0] s_awaddr_i;
  logic                   s_awvalid_i;
  logic                   s_awready_o;
  logic [`AXI_DATA_W-1:0] s_wdata_i;
  logic                   s_wvalid_i;
  logic                   s_wready_o;
  axi_resp_e              s_bresp_o;
  logic                   s_bvalid_o;
  logic                   s_bready_i;
  logic [`AXI_ADDR_W-1:0] s_araddr_i;
  logic                   s_arvalid_i;
  logic                   s_arready_o;
  logic [`AXI_DATA_W-1:0] s_rdata_o;
  axi_resp_e              s_rresp_o;
  logic                   s_rvalid_o;
  logic                   s_rready_i;

  logic [`AXI_DATA_W-1:0] model_q [`REG_COUNT];   // expected register contents
  axi_resp_e              exp_b_q [$];            // one entry per issued write
  logic [`AXI_ADDR_W-1:0] exp_r_addr_q [$];
  logic [`AXI_DATA_W-1:0] exp_r_data_q [$];
  axi_resp_e              exp_r_resp_q [$];
  int                     err_count;
  int                     tests_passed;
  int                     tests_failed;
  int                     test_num;
  int                     test_err_start;
  string                  test_name;

  axi_lite_regs_top axi_lite_regs_top_inst (
    .SAXI_aclk   (SAXI_aclk),   .rst         (rst),
    .s_awaddr_i  (s_awaddr_i),  .s_awvalid_i (s_awvalid_i), .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),   .s_wvalid_i  (s_wvalid_i),  .s_wready_o  (s_wready_o),
    .s_bresp_o   (s_bresp_o),   .s_bvalid_o  (s_bvalid_o),  .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),  .s_arvalid_i (s_arvalid_i), .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),   .s_rresp_o   (s_rresp_o),   .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i)
  );

  initial begin
    SAXI_aclk = 1'b0;
    forever #(CLK_NS / 2) SAXI_aclk = ~SAXI_aclk;
  end

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  // word aligned and inside base .. base + 16
  function automatic logic addr_decodes(input logic [`AXI_ADDR_W-1:0] addr);
    return (addr[1:0] == 2'b00) && (addr >= `REG_BASE_ADDR)
        && (addr < `REG_BASE_ADDR + `REG_COUNT * `REG_BYTE_OFS);
  endfunction

  function automatic int reg_index(input logic [`AXI_ADDR_W-1:0] addr);
    return int'((addr - `REG_BASE_ADDR) / `REG_BYTE_OFS);
  endfunction

  function automatic void ref_read(input logic [`AXI_ADDR_W-1:0] addr,
                                   output logic [`AXI_DATA_W-1:0] data, output axi_resp_e resp);
    if (addr_decodes(addr)) begin
      data = model_q[reg_index(addr)];
      resp = resp_okay;
    end else begin
      data = '0;   // miss reads as zero
      resp = resp_slverr;
    end
  endfunction

  function automatic axi_resp_e model_write(input logic [`AXI_ADDR_W-1:0] addr,
                                            input logic [`AXI_DATA_W-1:0] data);
    if (!addr_decodes(addr)) return resp_slverr;   // model untouched
    model_q[reg_index(addr)] = data;
    return resp_okay;
  endfunction

  function automatic int rand_below(input int n);
    return int'($urandom % n);
  endfunction

  // mostly legal, some misaligned, some past the window
  function automatic logic [`AXI_ADDR_W-1:0] pick_addr();
    int sel;
    sel = rand_below(10);
    if (sel < 8) return `REG_BASE_ADDR + `REG_BYTE_OFS * rand_below(`REG_COUNT);
    if (sel == 8) begin
      return `REG_BASE_ADDR + `REG_BYTE_OFS * rand_below(`REG_COUNT) + 1 + rand_below(3);
    end
    return `REG_BASE_ADDR + `REG_COUNT * `REG_BYTE_OFS + `REG_BYTE_OFS * rand_below(64);
  endfunction

  // ----------------------------------------------------------------------
  // channel drivers enter and leave just after a rising edge
  // ----------------------------------------------------------------------
  task automatic send_aw(input logic [`AXI_ADDR_W-1:0] addr, input int dly);
    repeat (dly) @(posedge SAXI_aclk);
    s_awaddr_i  <= addr;
    s_awvalid_i <= 1'b1;
    @(posedge SAXI_aclk);
    while (!s_awready_o) @(posedge SAXI_aclk);
    s_awvalid_i <= 1'b0;   // handshake on this edge
  endtask

  task automatic send_w(input logic [`AXI_DATA_W-1:0] data, input int dly);
    repeat (dly) @(posedge SAXI_aclk);
    s_wdata_i  <= data;
    s_wvalid_i <= 1'b1;
    @(posedge SAXI_aclk);
    while (!s_wready_o) @(posedge SAXI_aclk);
    s_wvalid_i <= 1'b0;
  endtask

  // mode 0 same cycle, 1 address first, 2 data first
  task automatic write_reg(input logic [`AXI_ADDR_W-1:0] addr, input logic [`AXI_DATA_W-1:0] data,
                           input int mode, input int gap, input int rdy_dly);
    exp_b_q.push_back(model_write(addr, data));
    case (mode)
      0: fork
        send_aw(addr, 0);
        send_w(data, 0);
      join
      1: fork
        send_aw(addr, 0);
        send_w(data, gap);
      join
      default: fork
        send_aw(addr, gap);
        send_w(data, 0);
      join
    endcase
    @(posedge SAXI_aclk);
    while (!s_bvalid_o) @(posedge SAXI_aclk);
    repeat (rdy_dly) @(posedge SAXI_aclk);   // back-pressure on b
    s_bready_i <= 1'b1;
    @(posedge SAXI_aclk);
    s_bready_i <= 1'b0;
  endtask

  task automatic read_reg(input logic [`AXI_ADDR_W-1:0] addr, input int rdy_dly);
    logic [`AXI_DATA_W-1:0] exp_data;
    axi_resp_e              exp_resp;
    ref_read(addr, exp_data, exp_resp);
    exp_r_addr_q.push_back(addr);
    exp_r_data_q.push_back(exp_data);
    exp_r_resp_q.push_back(exp_resp);
    s_araddr_i  <= addr;
    s_arvalid_i <= 1'b1;
    @(posedge SAXI_aclk);
    while (!s_arready_o) @(posedge SAXI_aclk);
    s_arvalid_i <= 1'b0;
    @(posedge SAXI_aclk);
    while (!s_rvalid_o) @(posedge SAXI_aclk);
    repeat (rdy_dly) @(posedge SAXI_aclk);   // back-pressure on r
    s_rready_i <= 1'b1;
    @(posedge SAXI_aclk);
    s_rready_i <= 1'b0;
  endtask

  task automatic read_all_regs(input int rdy_dly);
    for (int i = 0; i < `REG_COUNT; i++) begin
      read_reg(`REG_BASE_ADDR + `REG_BYTE_OFS * i, rdy_dly);
    end
  endtask

  task automatic open_test(input string name);
    test_num++;
    test_name      = name;
    test_err_start = err_count;
  endtask

  task automatic close_test();
    @(posedge SAXI_aclk);   // let the comparator take the last beat
    if (exp_b_q.size() != 0 || exp_r_data_q.size() != 0) begin
      $display("test %0d: %0d write and %0d read responses never arrived",
               test_num, exp_b_q.size(), exp_r_data_q.size());
      err_count++;
      exp_b_q.delete();
      exp_r_addr_q.delete();
      exp_r_data_q.delete();
      exp_r_resp_q.delete();
    end
    if (err_count == test_err_start) begin
      tests_passed++;
      $display("test %0d %s: passed", test_num, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", test_num, test_name, err_count - test_err_start);
    end
  endtask

  // ----------------------------------------------------------------------
  // comparator samples on the rising edge before any update
  // ----------------------------------------------------------------------
  initial begin : compare_responses
    logic                   prev_bvalid;
    logic                   prev_bready;
    logic                   prev_rvalid;
    logic                   prev_rready;
    axi_resp_e              prev_bresp;
    axi_resp_e              prev_rresp;
    logic [`AXI_DATA_W-1:0] prev_rdata;
    axi_resp_e              exp_resp;
    logic [`AXI_DATA_W-1:0] exp_data;
    logic [`AXI_ADDR_W-1:0] exp_addr;
    prev_bvalid = 1'b0;
    prev_rvalid = 1'b0;
    forever begin
      @(posedge SAXI_aclk);
      if (!rst) begin
        // a stalled beat must stay up and unchanged
        if (prev_bvalid && !prev_bready) begin
          if (!s_bvalid_o) begin
            $display("write response valid dropped before it was accepted");
            err_count++;
          end else if (s_bresp_o != prev_bresp) begin
            $display("error: s_bresp_o held 0x%h changed to 0x%h", prev_bresp, s_bresp_o);
            err_count++;
          end
        end
        if (prev_rvalid && !prev_rready) begin
          if (!s_rvalid_o) begin
            $display("read data valid dropped before it was accepted");
            err_count++;
          end else if (s_rdata_o != prev_rdata || s_rresp_o != prev_rresp) begin
            $display("error: s_rdata_o/s_rresp_o held 0x%h/0x%h changed to 0x%h/0x%h",
                     prev_rdata, prev_rresp, s_rdata_o, s_rresp_o);
            err_count++;
          end
        end
        // nothing new accepted while a response is pending
        if (s_bvalid_o && (s_awready_o || s_wready_o)) begin
          $display("write address or data ready high while the write response is pending");
          err_count++;
        end
        if (s_rvalid_o && s_arready_o) begin
          $display("read address ready high while read data is pending");
          err_count++;
        end
        if (s_bvalid_o && s_bready_i) begin
          if (exp_b_q.size() == 0) begin
            $display("write response arrived with no write outstanding");
            err_count++;
          end else begin
            exp_resp = exp_b_q.pop_front();
            if (s_bresp_o != exp_resp) begin
              $display("error: s_bresp_o expected 0x%h actual 0x%h", exp_resp, s_bresp_o);
              err_count++;
            end
          end
        end
        if (s_rvalid_o && s_rready_i) begin
          if (exp_r_data_q.size() == 0) begin
            $display("read data arrived with no read outstanding");
            err_count++;
          end else begin
            exp_addr = exp_r_addr_q.pop_front();
            exp_data = exp_r_data_q.pop_front();
            exp_resp = exp_r_resp_q.pop_front();
            if (s_rdata_o != exp_data) begin
              $display("error: s_rdata_o at 0x%h expected 0x%h actual 0x%h",
                       exp_addr, exp_data, s_rdata_o);
              err_count++;
            end
            if (s_rresp_o != exp_resp) begin
              $display("error: s_rresp_o at 0x%h expected 0x%h actual 0x%h",
                       exp_addr, exp_resp, s_rresp_o);
              err_count++;
            end
          end
        end
      end
      prev_bvalid = s_bvalid_o;
      prev_bready = s_bready_i;
      prev_bresp  = s_bresp_o;
      prev_rvalid = s_rvalid_o;
      prev_rready = s_rready_i;
      prev_rresp  = s_rresp_o;
      prev_rdata  = s_rdata_o;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge SAXI_aclk);
    $display("timeout: run still busy after %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    void'($urandom(32'h8832_5b0d));
    s_awaddr_i  <= '0;
    s_awvalid_i <= 1'b0;
    s_wdata_i   <= '0;
    s_wvalid_i  <= 1'b0;
    s_bready_i  <= 1'b0;
    s_araddr_i  <= '0;
    s_arvalid_i <= 1'b0;
    s_rready_i  <= 1'b0;
    rst         <= 1'b1;
    for (int i = 0; i < `REG_COUNT; i++) begin
      model_q[i] = '0;
    end
    repeat (RST_CYCLES) @(posedge SAXI_aclk);
    rst <= 1'b0;
    @(posedge SAXI_aclk);

    open_test("reset values");
    // readies up and no response pending straight out of reset
    if (!s_awready_o || !s_wready_o || !s_arready_o || s_bvalid_o || s_rvalid_o) begin
      $display("handshake outputs not at their idle values after reset");
      err_count++;
    end
    read_all_regs(0);
    close_test();

    open_test("same cycle writes");
    for (int i = 0; i < `REG_COUNT; i++) begin
      write_reg(`REG_BASE_ADDR + `REG_BYTE_OFS * i, $urandom, 0, 0, rand_below(4));
    end
    read_all_regs(0);
    close_test();

    open_test("address first and data first");
    for (int i = 0; i < 2 * `REG_COUNT; i++) begin
      write_reg(`REG_BASE_ADDR + `REG_BYTE_OFS * (i % `REG_COUNT), $urandom,
                (i < `REG_COUNT) ? 1 : 2, rand_below(6), rand_below(4));
    end
    read_all_regs(1);
    close_test();

    open_test("invalid addresses");
    write_reg(`REG_BASE_ADDR + 32'h10, $urandom, 0, 0, 0);   // one past the window
    write_reg(`REG_BASE_ADDR + 32'h2, $urandom, 1, 2, 1);    // misaligned
    write_reg(`REG_BASE_ADDR - 32'h4, $urandom, 2, 3, 0);    // below base
    read_reg(`REG_BASE_ADDR + 32'h10, 0);
    read_reg(`REG_BASE_ADDR + 32'h2, 2);
    read_reg(`REG_BASE_ADDR - 32'h4, 1);
    read_all_regs(0);
    close_test();

    open_test("back-pressure");
    for (int i = 0; i < `REG_COUNT; i++) begin
      write_reg(`REG_BASE_ADDR + `REG_BYTE_OFS * i, $urandom, rand_below(3), rand_below(6),
                4 + rand_below(9));
    end
    for (int i = 0; i < `REG_COUNT; i++) begin
      read_reg(`REG_BASE_ADDR + `REG_BYTE_OFS * i, 4 + rand_below(9));
    end
    close_test();

    open_test("random traffic");
    for (int n = 0; n < 200; n++) begin
      if (rand_below(2) == 0) begin
        write_reg(pick_addr(), $urandom, rand_below(3), rand_below(6), rand_below(8));
      end else begin
        read_reg(pick_addr(), rand_below(8));
      end
    end
    close_test();

    $display("tests passed %0d failed %0d, check errors %0d",
             tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
